//--- eeprom_macros.svh
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

`define EE_ADDR_W 11 // 2 Kbyte part
`define EE_DATA_W 8
`define EE_DEV_CODE 4'b1010 // 24Cxx device type

// clk cycles per scl half period
`define SCL_HALF_DEFAULT 4

`define APB_ADDR_W 8
`define APB_DATA_W 32

`define REG_ADDR_OFS 8'h00
`define REG_WDATA_OFS 8'h04
`define REG_CMD_OFS 8'h08
`define REG_STATUS_OFS 8'h0C
`define REG_RDATA_OFS 8'h10

`endif

//--- i2c_pkg.sv
package i2c_pkg;

    // transaction states, one value each
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL,     // control byte, r/w low
        ST_ADDR,     // word address
        ST_DATA_WR,
        ST_RESTART,  // repeated start before the read
        ST_CTRL_RD,  // control byte, r/w high
        ST_DATA_RD,
        ST_MNACK,    // master nack after the read byte
        ST_STOP,
        ST_DONE
    } ctrl_state_e;

    // where we are inside one scl period
    typedef enum logic [1:0] {
        PH_LOW,
        PH_RISE,  // last cycle of the low half
        PH_HIGH,
        PH_FALL   // last cycle of the high half
    } bit_phase_e;

endpackage

//--- apb_regs_pkg.sv
package apb_regs_pkg;

    // decoded register select
    typedef enum logic [2:0] {
        SEL_ADDR,
        SEL_WDATA,
        SEL_CMD,
        SEL_STATUS,
        SEL_RDATA,
        SEL_NONE
    } reg_sel_e;

    // command register bit 0
    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } cmd_op_e;

endpackage

//--- apb_regs.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module apb_regs (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`APB_ADDR_W-1:0]  paddr,
    input  logic [`APB_DATA_W-1:0]  pwdata,
    input  logic                    busy,
    input  logic                    finish,
    input  logic                    nack,
    input  logic                    rdata_load,
    input  logic [`EE_DATA_W-1:0]   rx_byte,
    output logic [`APB_DATA_W-1:0]  prdata,
    output logic                    pslverr,
    output logic                    start,
    output apb_regs_pkg::cmd_op_e   op,
    output logic [`EE_ADDR_W-1:0]   ee_addr,
    output logic [`EE_DATA_W-1:0]   wdata
);
    import apb_regs_pkg::*;

    reg_sel_e               sel;
    logic                   wr_en;
    logic                   rd_en;
    logic                   busy_any;
    logic                   cmd_ok;
    logic                   done_q;
    logic                   nack_q;
    logic [`EE_DATA_W-1:0]  rdata_q;

    always_comb
    begin
        case (paddr)
            `REG_ADDR_OFS:   sel = SEL_ADDR;
            `REG_WDATA_OFS:  sel = SEL_WDATA;
            `REG_CMD_OFS:    sel = SEL_CMD;
            `REG_STATUS_OFS: sel = SEL_STATUS;
            `REG_RDATA_OFS:  sel = SEL_RDATA;
            default:         sel = SEL_NONE;
        endcase
    end

    assign wr_en    = psel & penable & pwrite;
    assign rd_en    = psel & penable & ~pwrite;
    assign busy_any = busy | start; // start still in flight counts too
    assign cmd_ok   = wr_en && (sel == SEL_CMD) && !busy_any;
    assign pslverr  = wr_en && (sel == SEL_CMD) && busy_any;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start  <= 1'b0;
            op     <= CMD_WRITE;
            done_q <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            start <= cmd_ok;
            if (cmd_ok)
            begin
                op     <= cmd_op_e'(pwdata[0]);
                done_q <= 1'b0;
                nack_q <= 1'b0;
            end
            else if (finish)
            begin
                done_q <= 1'b1;
                nack_q <= nack;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_en && sel == SEL_ADDR)
            ee_addr <= pwdata[`EE_ADDR_W-1:0];
        if (wr_en && sel == SEL_WDATA)
            wdata <= pwdata[`EE_DATA_W-1:0];
        if (rdata_load)
            rdata_q <= rx_byte;
    end

    always_comb
    begin
        prdata = '0;
        if (rd_en)
        begin
            case (sel)
                SEL_ADDR:   prdata[`EE_ADDR_W-1:0] = ee_addr;
                SEL_WDATA:  prdata[`EE_DATA_W-1:0] = wdata;
                SEL_CMD:    prdata[0] = op;
                SEL_STATUS: prdata[2:0] = {nack_q, done_q, busy_any};
                SEL_RDATA:  prdata[`EE_DATA_W-1:0] = rdata_q;
                default:    prdata = '0;
            endcase
        end
    end

endmodule

//--- i2c_ctrl_fsm.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module i2c_ctrl_fsm (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    start,
    input  apb_regs_pkg::cmd_op_e   op,
    input  logic [`EE_ADDR_W-1:0]   ee_addr,
    input  logic [`EE_DATA_W-1:0]   wdata,
    input  logic                    tick_low_mid,
    input  logic                    tick_high_mid,
    input  logic                    byte_end,
    input  logic                    ack_bit,
    output logic                    busy,
    output logic                    finish,
    output logic                    nack,
    output logic                    rdata_load,
    output logic                    scl_run,
    output logic                    load,
    output logic [`EE_DATA_W-1:0]   tx_byte,
    output logic                    shift_tx,
    output logic                    shift_rx,
    output logic                    force_low,
    output logic                    release_sda
);
    import i2c_pkg::*;
    import apb_regs_pkg::*;

    ctrl_state_e            state;
    ctrl_state_e            state_nxt;
    cmd_op_e                op_q;
    logic                   nack_q;
    logic [2:0]             rd_cnt;   // data bits sampled in the read byte
    logic [`EE_ADDR_W-1:0]  addr_q;
    logic [`EE_DATA_W-1:0]  data_q;
    logic                   tx_state;
    logic                   acked_state;
    logic                   is_write;

    // high address bits ride in the control byte
    assign tx_state    = state inside {ST_CTRL, ST_ADDR, ST_DATA_WR, ST_CTRL_RD};
    assign acked_state = tx_state;
    assign is_write    = (op_q == CMD_WRITE);

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:    if (start) state_nxt = ST_START;
            ST_START:   if (tick_high_mid) state_nxt = ST_CTRL;
            ST_CTRL:    if (byte_end) state_nxt = ack_bit ? ST_STOP : ST_ADDR;
            ST_ADDR:
            begin
                if (byte_end)
                begin
                    if (ack_bit)
                        state_nxt = ST_STOP;
                    else
                        state_nxt = is_write ? ST_DATA_WR : ST_RESTART;
                end
            end
            ST_DATA_WR: if (byte_end) state_nxt = ST_STOP;
            ST_RESTART: if (tick_high_mid) state_nxt = ST_CTRL_RD;
            ST_CTRL_RD: if (byte_end) state_nxt = ack_bit ? ST_STOP : ST_DATA_RD;
            ST_DATA_RD: if (tick_high_mid && rd_cnt == 3'd7) state_nxt = ST_MNACK;
            ST_MNACK:   if (byte_end) state_nxt = ST_STOP;
            ST_STOP:    if (tick_high_mid) state_nxt = ST_DONE;
            default:    state_nxt = ST_IDLE; // done lasts one cycle
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= ST_IDLE;
            op_q   <= CMD_WRITE;
            nack_q <= 1'b0;
            rd_cnt <= 3'd0;
        end
        else
        begin
            state <= state_nxt;
            if (state == ST_IDLE && start)
            begin
                op_q   <= op;
                nack_q <= 1'b0;
            end
            else if (acked_state && byte_end && ack_bit)
                nack_q <= 1'b1;
            if (load)
                rd_cnt <= 3'd0;
            else if (state == ST_DATA_RD && tick_high_mid)
                rd_cnt <= rd_cnt + 3'd1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && start)
        begin
            addr_q <= ee_addr;
            data_q <= wdata;
        end
    end

    always_comb
    begin
        case (state)
            ST_START:   tx_byte = {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:8], 1'b0};
            ST_CTRL:    tx_byte = addr_q[7:0];
            ST_ADDR:    tx_byte = data_q;
            ST_RESTART: tx_byte = {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:8], 1'b1};
            default:    tx_byte = '1; // all released while reading
        endcase
    end

    assign load = ((state == ST_START || state == ST_RESTART) && tick_high_mid)
                | (byte_end && !ack_bit
                   && (state == ST_CTRL || state == ST_CTRL_RD
                       || (state == ST_ADDR && is_write)));

    assign shift_tx    = tx_state && tick_low_mid;
    assign shift_rx    = (tx_state || state == ST_DATA_RD || state == ST_MNACK) && tick_high_mid;
    assign force_low   = ((state == ST_START || state == ST_RESTART) && tick_high_mid)
                       | (state == ST_STOP && tick_low_mid);
    assign release_sda = ((state == ST_RESTART || state == ST_DATA_RD || state == ST_MNACK)
                          && tick_low_mid)
                       | (state == ST_STOP && tick_high_mid); // stop condition

    assign busy       = (state != ST_IDLE) && (state != ST_DONE);
    assign scl_run    = busy;
    assign finish     = (state == ST_DONE);
    assign nack       = nack_q;
    assign rdata_load = (state == ST_MNACK) && byte_end;

endmodule

//--- scl_timer.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module scl_timer #(
    parameter int SCL_HALF = `SCL_HALF_DEFAULT
) (
    input  logic CLK,
    input  logic RESET,
    input  logic scl_run,
    input  logic load,
    output logic scl,
    output logic tick_low_mid,
    output logic tick_high_mid,
    output logic byte_end
);
    import i2c_pkg::*;

    localparam int CNT_W = $clog2(SCL_HALF);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(SCL_HALF - 1);
    localparam logic [CNT_W-1:0] MID  = CNT_W'(SCL_HALF / 2 - 1);

    logic [CNT_W-1:0] cnt;
    logic [3:0]       slot;   // scl periods since last load
    bit_phase_e       phase;

    always_comb
    begin
        if (!scl)
            phase = (cnt == LAST) ? PH_RISE : PH_LOW;
        else
            phase = (cnt == LAST) ? PH_FALL : PH_HIGH;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET || !scl_run)
        begin
            cnt <= '0;
            scl <= 1'b1; // bus idles high
        end
        else if (cnt == LAST)
        begin
            cnt <= '0;
            scl <= ~scl;
        end
        else
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET || !scl_run || load)
            slot <= 4'd0;
        else if (phase == PH_RISE)
            slot <= slot + 4'd1;
    end

    assign tick_low_mid  = scl_run && phase == PH_LOW && cnt == MID;
    assign tick_high_mid = scl_run && phase == PH_HIGH && cnt == MID;
    assign byte_end      = scl_run && phase == PH_FALL && slot == 4'd9; // ack slot over

endmodule

//--- i2c_shifter.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module i2c_shifter (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   load,
    input  logic [`EE_DATA_W-1:0]  tx_byte,
    input  logic                   shift_tx,
    input  logic                   shift_rx,
    input  logic                   force_low,
    input  logic                   release_sda,
    input  logic                   sda_in,
    output logic                   sda_oe,
    output logic [`EE_DATA_W-1:0]  rx_byte,
    output logic                   ack_bit
);

    logic [`EE_DATA_W-1:0] tx_sr;
    logic [`EE_DATA_W:0]   rx_sr;   // 8 data bits plus the ninth slot

    always_ff @(posedge CLK)
    begin
        if (load)
            tx_sr <= tx_byte;
        else if (shift_tx)
            tx_sr <= {tx_sr[`EE_DATA_W-2:0], 1'b1}; // ones fill, slot nine released
        if (shift_rx)
            rx_sr <= {rx_sr[`EE_DATA_W-1:0], sda_in};
    end

    // open drain, only ever pull low
    always_ff @(posedge CLK)
    begin
        if (RESET)
            sda_oe <= 1'b0;
        else if (force_low)
            sda_oe <= 1'b1;
        else if (release_sda)
            sda_oe <= 1'b0;
        else if (shift_tx)
            sda_oe <= ~tx_sr[`EE_DATA_W-1]; // msb first
    end

    assign rx_byte = rx_sr[`EE_DATA_W:1];
    assign ack_bit = rx_sr[0];   // high means nack

endmodule

//--- eeprom_master_top.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module eeprom_master_top #(
    parameter int SCL_HALF = `SCL_HALF_DEFAULT
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`APB_ADDR_W-1:0]  paddr,
    input  logic [`APB_DATA_W-1:0]  pwdata,
    output logic [`APB_DATA_W-1:0]  prdata,
    output logic                    pslverr,
    output logic                    scl,
    output logic                    sda_oe,
    input  logic                    sda_in,
    output logic                    xfer_done
);
    import apb_regs_pkg::*;

    cmd_op_e                op;
    logic                   start, busy, finish, nack, rdata_load;
    logic [`EE_ADDR_W-1:0]  ee_addr;
    logic [`EE_DATA_W-1:0]  wdata, rx_byte, tx_byte;
    logic                   scl_run, load, shift_tx, shift_rx, force_low, release_sda;
    logic                   tick_low_mid, tick_high_mid, byte_end, ack_bit;

    apb_regs u_regs (
        .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .busy(busy), .finish(finish), .nack(nack),
        .rdata_load(rdata_load), .rx_byte(rx_byte), .prdata(prdata), .pslverr(pslverr),
        .start(start), .op(op), .ee_addr(ee_addr), .wdata(wdata)
    );

    i2c_ctrl_fsm u_fsm (
        .CLK(CLK), .RESET(RESET), .start(start), .op(op), .ee_addr(ee_addr),
        .wdata(wdata), .tick_low_mid(tick_low_mid), .tick_high_mid(tick_high_mid),
        .byte_end(byte_end), .ack_bit(ack_bit), .busy(busy), .finish(finish),
        .nack(nack), .rdata_load(rdata_load), .scl_run(scl_run), .load(load),
        .tx_byte(tx_byte), .shift_tx(shift_tx), .shift_rx(shift_rx),
        .force_low(force_low), .release_sda(release_sda)
    );

    scl_timer #(.SCL_HALF(SCL_HALF)) u_timer (
        .CLK(CLK), .RESET(RESET), .scl_run(scl_run), .load(load), .scl(scl),
        .tick_low_mid(tick_low_mid), .tick_high_mid(tick_high_mid), .byte_end(byte_end)
    );

    i2c_shifter u_shifter (
        .CLK(CLK), .RESET(RESET), .load(load), .tx_byte(tx_byte), .shift_tx(shift_tx),
        .shift_rx(shift_rx), .force_low(force_low), .release_sda(release_sda),
        .sda_in(sda_in), .sda_oe(sda_oe), .rx_byte(rx_byte), .ack_bit(ack_bit)
    );

    assign xfer_done = finish; // one cycle, busy drops with it

endmodule

//--- eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic present,
    output logic pull
);

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    logic [7:0]  sh;
    int          bit_n;
    int          byte_n;
    int          send_n;
    logic        active;
    logic        ack_due;
    logic        in_ack;
    logic        rd_mode;
    logic        sending;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = {i[10:8], 5'b0} ^ i[7:0]; // every address bit shows up
        pull    = 1'b0;
        active  = 1'b0;
        ack_due = 1'b0;
        in_ack  = 1'b0;
        sending = 1'b0;
        rd_mode = 1'b0;
        ptr     = '0;
        sh      = '0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active  = present;
            bit_n   = 0;
            byte_n  = 0;
            ack_due = 1'b0;
            in_ack  = 1'b0;
            sending = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            active  = 1'b0; // stop
            sending = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active && !in_ack && !sending)
        begin
            sh = {sh[6:0], sda};
            bit_n++;
            if (bit_n == 8)
            begin
                bit_n = 0;
                if (byte_n == 0)
                begin
                    if (sh[7:4] == 4'b1010)
                    begin
                        ptr[10:8] = sh[3:1]; // block select from control byte
                        rd_mode   = sh[0];
                        ack_due   = 1'b1;
                    end
                    else
                        active = 1'b0;
                end
                else if (byte_n == 1)
                begin
                    ptr[7:0] = sh;
                    ack_due  = 1'b1;
                end
                else if (byte_n == 2)
                begin
                    mem[ptr] = sh;
                    ack_due  = 1'b1;
                end
                else
                    active = 1'b0; // no page writes
                byte_n++;
            end
        end
    end

    // sda only changes while scl is low
    always @(negedge scl)
    begin
        if (ack_due)
        begin
            pull    = 1'b1;
            ack_due = 1'b0;
            in_ack  = 1'b1;
        end
        else if (in_ack)
        begin
            in_ack = 1'b0;
            pull   = 1'b0;
            if (rd_mode && byte_n == 1)
            begin
                sending = 1'b1;
                send_n  = 7;
                pull    = ~mem[ptr][7];
            end
        end
        else if (sending)
        begin
            if (send_n == 0)
            begin
                sending = 1'b0; // master nack slot, just let go
                pull    = 1'b0;
                active  = 1'b0;
            end
            else
            begin
                send_n--;
                pull = ~mem[ptr][send_n];
            end
        end
    end

endmodule

//--- eeprom_master_chk.sv
`timescale 1ns/1ps

module eeprom_master_chk (
    input logic CLK,
    input logic RESET,
    input logic scl,
    input logic sda_in,
    input logic sda_oe,
    input logic xfer_done,
    input logic busy,
    input logic force_low,
    input logic release_sda
);

    // only start and stop may move sda while scl is high
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_in != $past(sda_in)) |-> $past(force_low || release_sda))
        else $error("sda changed while scl high");

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        xfer_done |=> !xfer_done)
        else $error("xfer_done longer than one cycle");

    a_idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> (scl && !sda_oe))
        else $error("bus not idle while not busy");

endmodule

bind eeprom_master_top eeprom_master_chk chk0 (
    .CLK(CLK), .RESET(RESET), .scl(scl), .sda_in(sda_in), .sda_oe(sda_oe),
    .xfer_done(xfer_done), .busy(busy), .force_low(force_low), .release_sda(release_sda)
);

//--- tb_eeprom_master.sv
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module tb_eeprom_master;

    localparam int WAIT_LIMIT = 4000; // well above the ~350 cycles of a read

    logic                    CLK;
    logic                    RESET;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`APB_ADDR_W-1:0]  paddr;
    logic [`APB_DATA_W-1:0]  pwdata;
    logic [`APB_DATA_W-1:0]  prdata;
    logic                    pslverr;
    logic                    scl;
    logic                    sda_oe;
    logic                    sda;
    logic                    xfer_done;
    logic                    present;
    logic                    model_pull;

    assign sda = ~(sda_oe | model_pull); // open drain wire with pull-up

    eeprom_master_top dut0 (
        .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda), .xfer_done(xfer_done)
    );

    eeprom_model ee0 (.scl(scl), .sda(sda), .present(present), .pull(model_pull));

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_byte(input string name, input logic [`EE_DATA_W-1:0] exp,
                              input logic [`EE_DATA_W-1:0] act);
        if (act !== exp)
            abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_status(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp)
            abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
    endtask

    task automatic apb_write(input logic [`APB_ADDR_W-1:0] a, input logic [`APB_DATA_W-1:0] d,
                             output logic err);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= a;
        pwdata  <= d;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        err = pslverr; // middle of the access cycle
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [`APB_ADDR_W-1:0] a, output logic [`APB_DATA_W-1:0] d);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= a;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        d = prdata;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        while (xfer_done !== 1'b1)
        begin
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT)
                abort_run($sformatf("%s never finished, xfer_done did not come", name));
        end
    endtask

    task automatic run_op(input byte op_c, input logic [`EE_ADDR_W-1:0] addr,
                          input logic [`EE_DATA_W-1:0] data, input logic exp_nack,
                          input string name);
        logic                   err;
        logic [`APB_DATA_W-1:0] rd;
        present <= (op_c != "X");
        apb_write(`REG_ADDR_OFS, 32'(addr), err);
        apb_write(`REG_WDATA_OFS, 32'(data), err);
        apb_write(`REG_CMD_OFS, (op_c == "R") ? 32'd1 : 32'd0, err);
        if (err)
            abort_run($sformatf("%s command refused while idle", name));
        apb_write(`REG_CMD_OFS, 32'd0, err); // second command while busy
        if (!err)
            abort_run($sformatf("%s command during busy was not refused", name));
        apb_read(`REG_STATUS_OFS, rd);
        check_status({name, " busy status"}, 3'b001, rd[2:0]); // old done and nack gone
        wait_done(name);
        apb_read(`REG_STATUS_OFS, rd);
        check_status({name, " status"}, {exp_nack, 2'b10}, rd[2:0]);
        if (op_c == "R" && !exp_nack)
        begin
            apb_read(`REG_RDATA_OFS, rd);
            check_byte({name, " rdata"}, data, rd[`EE_DATA_W-1:0]);
        end
        present <= 1'b1;
    endtask

    initial
    begin
        int                     fd;
        int                     n;
        int                     line_no;
        string                  line;
        byte                    op_c;
        logic [`EE_ADDR_W-1:0]  addr;
        logic [`EE_DATA_W-1:0]  data;
        int                     exp_nack;
        logic [`APB_DATA_W-1:0] rd;

        void'($urandom(32'ha73f554e));
        RESET   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        present = 1'b1;
        line_no = 0;
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);

        if (scl !== 1'b1 || sda_oe !== 1'b0)
            abort_run("bus pins not idle after reset");
        apb_read(`REG_STATUS_OFS, rd);
        check_status("reset status", 3'b000, rd[2:0]);

        fd = $fopen("eeprom_testdata.txt", "r");
        if (fd == 0)
            abort_run("cannot open eeprom_testdata.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%c %h %h %d", op_c, addr, data, exp_nack);
            if (n != 4)
                abort_run($sformatf("bad line %0d in the data file", line_no));
            run_op(op_c, addr, data, exp_nack[0],
                   $sformatf("line %0d %c %h", line_no, op_c, addr));
            repeat ($urandom_range(30, 5)) @(posedge CLK); // idle gap for the write cycle
        end
        $fclose(fd);

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- eeprom_testdata.txt
# op addr data nack: W write, R read and compare data, X write with no device
# addr and data in hex, nack is the expected status nack bit
W 0a5 3c 0
R 0a5 3c 0
W 1a5 c3 0
W 7a5 81 0
R 0a5 3c 0
R 1a5 c3 0
R 7a5 81 0
R 3a5 c5 0
X 2a5 55 1
R 2a5 e5 0

//--- list.f
+incdir+.
i2c_pkg.sv
apb_regs_pkg.sv
apb_regs.sv
i2c_ctrl_fsm.sv
scl_timer.sv
i2c_shifter.sv
eeprom_master_top.sv
eeprom_model.sv
eeprom_master_chk.sv
tb_eeprom_master.sv

//--- Makefile
TOP = tb_eeprom_master

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f
	out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir
